/* Makefile */
TOP = tb_mmu

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	  echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module mmu_top

clean:
	rm -rf obj_dir

/* access_check.sv */
`timescale 1ns/1ps

module access_check (
  input  logic                        v_i,
  input  mmu_pkg::mem_op_e            op_i,
  input  logic                        translation_en_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        uncached_mode_i,
  input  mmu_pkg::pte_leaf_t          entry_i,
  input  logic [mmu_pkg::PADDR_W-1:0] paddr_i,
  output logic                        load_page_fault_o,
  output logic                        store_page_fault_o,
  output logic                        load_access_fault_o,
  output logic                        store_access_fault_o
);

  logic is_store;
  logic priv_fault;
  logic write_fault;
  logic did_fault;
  logic mode_fault;

  assign is_store = (op_i == mmu_pkg::op_sd) || (op_i == mmu_pkg::op_sw);

  // S mode needs SUM for user pages, U mode needs user pages
  assign priv_fault = ((priv_i == mmu_pkg::priv_s) && !sum_i && entry_i.u)
                    || ((priv_i == mmu_pkg::priv_u) && !entry_i.u);
  assign write_fault = is_store && (!entry_i.w || !entry_i.d);

  assign load_page_fault_o  = v_i && translation_en_i && !is_store && priv_fault;
  assign store_page_fault_o = v_i && translation_en_i && is_store
                              && (priv_fault || write_fault);

  // Only domain zero is reachable
  assign did_fault  = paddr_i[mmu_pkg::PADDR_W-1 -: mmu_pkg::DID_W] != '0;
  assign mode_fault = uncached_mode_i && paddr_i[mmu_pkg::CACHED_BIT];

  // Page faults take priority
  assign load_access_fault_o  = v_i && !is_store && (did_fault || mode_fault)
                                && !load_page_fault_o;
  assign store_access_fault_o = v_i && is_store && (did_fault || mode_fault)
                                && !store_page_fault_o;

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
  parameter int MEM_DWORDS = 64
) (
  input  logic                        clk_i,
  input  logic                        rd_v_i,
  input  logic                        wr_v_i,
  input  mmu_pkg::mem_op_e            op_i,
  input  logic [mmu_pkg::PADDR_W-1:0] paddr_i,
  input  logic [mmu_pkg::DWORD_W-1:0] wdata_i,
  output logic [mmu_pkg::DWORD_W-1:0] rdata_o
);

  localparam int IDX_W  = (MEM_DWORDS > 1) ? $clog2(MEM_DWORDS) : 1;
  localparam int WORD_W = mmu_pkg::DWORD_W / 2;

  logic [mmu_pkg::DWORD_W-1:0] mem_r [MEM_DWORDS];
  logic [mmu_pkg::DWORD_W-1:0] rd_r;
  logic                        lw_r;
  logic                        hi_r;

  logic [IDX_W-1:0]  idx;
  logic              hi_word;
  logic [WORD_W-1:0] word_sel;

  // Dword index above the byte offset
  assign idx     = paddr_i[3 +: IDX_W];
  assign hi_word = paddr_i[2];

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      case (op_i)
        mmu_pkg::op_sd: mem_r[idx] <= wdata_i;
        mmu_pkg::op_sw: begin
          if (hi_word) begin
            mem_r[idx][WORD_W +: WORD_W] <= wdata_i[WORD_W-1:0];
          end else begin
            mem_r[idx][0 +: WORD_W] <= wdata_i[WORD_W-1:0];
          end
        end
        default: ;
      endcase
    end
    if (rd_v_i) begin
      rd_r <= mem_r[idx];
      lw_r <= (op_i == mmu_pkg::op_lw);
      hi_r <= hi_word;
    end
  end

  assign word_sel = hi_r ? rd_r[WORD_W +: WORD_W] : rd_r[0 +: WORD_W];
  assign rdata_o  = lw_r ? {{WORD_W{word_sel[WORD_W-1]}}, word_sel} : rd_r;

endmodule

/* dtlb.sv */
`timescale 1ns/1ps

module dtlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       flush_i,
  input  logic                       lookup_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0] lookup_vtag_i,
  input  logic                       fill_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0] fill_vtag_i,
  input  mmu_pkg::pte_leaf_t         fill_entry_i,
  output logic                       hit_o,
  output mmu_pkg::pte_leaf_t         entry_o
);

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0]     valid_r;
  logic [mmu_pkg::VTAG_W-1:0] vtag_r [TLB_ENTRIES];
  mmu_pkg::pte_leaf_t         entry_r [TLB_ENTRIES];
  logic [IDX_W-1:0]           victim_r;

  logic [TLB_ENTRIES-1:0] lookup_match;
  logic [TLB_ENTRIES-1:0] fill_match;
  logic [IDX_W-1:0]       hit_idx;
  logic [IDX_W-1:0]       fill_idx;
  logic                   fill_present;

  always_comb begin
    lookup_match = '0;
    fill_match   = '0;
    hit_idx      = '0;
    fill_idx     = victim_r;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      lookup_match[i] = valid_r[i] && (vtag_r[i] == lookup_vtag_i);
      fill_match[i]   = valid_r[i] && (vtag_r[i] == fill_vtag_i);
      if (lookup_match[i]) begin
        hit_idx = IDX_W'(i);
      end
      // Refill of a present tag reuses its slot
      if (fill_match[i]) begin
        fill_idx = IDX_W'(i);
      end
    end
  end

  assign fill_present = |fill_match;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      victim_r <= '0;
      hit_o    <= 1'b0;
    end else begin
      hit_o <= lookup_v_i && (|lookup_match);
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[fill_idx] <= 1'b1;
      end
      if (fill_v_i && !fill_present) begin
        if (victim_r == IDX_W'(TLB_ENTRIES - 1)) begin
          victim_r <= '0;
        end else begin
          victim_r <= victim_r + 1'b1;
        end
      end
    end
  end

  // Tag and entry storage is read before the fill lands
  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      vtag_r[fill_idx]  <= fill_vtag_i;
      entry_r[fill_idx] <= fill_entry_i;
    end
    entry_o <= entry_r[hit_idx];
  end

  a_single_match: assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v_i |-> $onehot0(lookup_match));

endmodule

/* list.f */
mmu_pkg.sv
dtlb.sv
access_check.sv
data_mem.sv
resp_credit.sv
mmu_top.sv
tb_mmu.sv

/* mmu_pkg.sv */
package mmu_pkg;

  // Sv39 style address split
  localparam int VADDR_W = 39;
  localparam int PADDR_W = 40;
  localparam int PGOFF_W = 12;
  localparam int VTAG_W  = VADDR_W - PGOFF_W;
  localparam int PTAG_W  = PADDR_W - PGOFF_W;

  localparam int DWORD_W = 64;

  // Domain id sits in the top bits of the physical address
  localparam int DID_W = 3;

  // Set for cacheable memory
  localparam int CACHED_BIT = 31;

  typedef enum logic [1:0] {
    op_ld = 2'b00,
    op_lw = 2'b01,
    op_sd = 2'b10,
    op_sw = 2'b11
  } mem_op_e;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11
  } priv_e;

  // Leaf PTE as cached in the TLB
  typedef struct packed {
    logic [PTAG_W-1:0] ptag;
    logic              u;
    logic              w;
    logic              d;
  } pte_leaf_t;

endpackage

/* mmu_top.sv */
`timescale 1ns/1ps

module mmu_top #(
  parameter int TLB_ENTRIES  = 4,
  parameter int MEM_DWORDS   = 64,
  parameter int RESP_CREDITS = 2
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        cmd_v_i,
  input  mmu_pkg::mem_op_e            cmd_op_i,
  input  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i,
  input  logic [mmu_pkg::DWORD_W-1:0] cmd_data_i,
  output logic                        cmd_ready_o,

  input  logic                        chk_poison_i,

  input  logic                        translation_en_i,
  input  mmu_pkg::priv_e              priv_i,
  input  logic                        sum_i,
  input  logic                        uncached_mode_i,

  input  logic                        fill_v_i,
  input  logic [mmu_pkg::VTAG_W-1:0]  fill_vtag_i,
  input  mmu_pkg::pte_leaf_t          fill_entry_i,
  input  logic                        flush_i,

  input  logic                        resp_credit_i,

  output logic                        resp_v_o,
  output logic [mmu_pkg::DWORD_W-1:0] resp_data_o,
  output logic [mmu_pkg::VADDR_W-1:0] resp_vaddr_o,
  output logic                        resp_tlb_miss_o,
  output logic                        resp_load_page_fault_o,
  output logic                        resp_store_page_fault_o,
  output logic                        resp_load_access_fault_o,
  output logic                        resp_store_access_fault_o
);

  localparam int OWED_W = $clog2(RESP_CREDITS + 2);

  logic cmd_accept;

  // Stage 1
  logic                        s1_v_r;
  mmu_pkg::mem_op_e            s1_op_r;
  logic [mmu_pkg::VADDR_W-1:0] s1_vaddr_r;
  logic [mmu_pkg::DWORD_W-1:0] s1_data_r;

  logic                        tlb_hit;
  mmu_pkg::pte_leaf_t          tlb_entry;
  logic [mmu_pkg::VTAG_W-1:0]  s1_vtag;
  logic [mmu_pkg::PTAG_W-1:0]  s1_ptag;
  logic [mmu_pkg::PADDR_W-1:0] s1_paddr;
  logic                        s1_miss;
  logic                        s1_live;
  logic                        s1_store;
  logic                        s1_fault;

  logic lpf;
  logic spf;
  logic laf;
  logic saf;

  logic [OWED_W-1:0] owed_r;

  assign cmd_accept = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      s1_op_r    <= cmd_op_i;
      s1_vaddr_r <= cmd_vaddr_i;
      s1_data_r  <= cmd_data_i;
    end
  end

  dtlb #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) u_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .lookup_v_i   (cmd_accept && translation_en_i),
    .lookup_vtag_i(cmd_vaddr_i[mmu_pkg::VADDR_W-1:mmu_pkg::PGOFF_W]),
    .fill_v_i     (fill_v_i),
    .fill_vtag_i  (fill_vtag_i),
    .fill_entry_i (fill_entry_i),
    .hit_o        (tlb_hit),
    .entry_o      (tlb_entry)
  );

  // Bare mode maps the vtag straight through
  assign s1_vtag  = s1_vaddr_r[mmu_pkg::VADDR_W-1:mmu_pkg::PGOFF_W];
  assign s1_ptag  = translation_en_i ? tlb_entry.ptag
                  : {{(mmu_pkg::PTAG_W - mmu_pkg::VTAG_W){1'b0}}, s1_vtag};
  assign s1_paddr = {s1_ptag, s1_vaddr_r[mmu_pkg::PGOFF_W-1:0]};
  assign s1_miss  = translation_en_i && !tlb_hit;

  assign s1_live  = s1_v_r && !chk_poison_i;
  assign s1_store = (s1_op_r == mmu_pkg::op_sd) || (s1_op_r == mmu_pkg::op_sw);

  access_check u_access_check (
    .v_i                 (s1_v_r && !s1_miss),
    .op_i                (s1_op_r),
    .translation_en_i    (translation_en_i),
    .priv_i              (priv_i),
    .sum_i               (sum_i),
    .uncached_mode_i     (uncached_mode_i),
    .entry_i             (tlb_entry),
    .paddr_i             (s1_paddr),
    .load_page_fault_o   (lpf),
    .store_page_fault_o  (spf),
    .load_access_fault_o (laf),
    .store_access_fault_o(saf)
  );

  assign s1_fault = lpf || spf || laf || saf;

  // Memory sees only surviving, translated, fault free stores
  data_mem #(
    .MEM_DWORDS(MEM_DWORDS)
  ) u_data_mem (
    .clk_i  (clk_i),
    .rd_v_i (s1_live && !s1_miss),
    .wr_v_i (s1_live && s1_store && !s1_miss && !s1_fault),
    .op_i   (s1_op_r),
    .paddr_i(s1_paddr),
    .wdata_i(s1_data_r),
    .rdata_o(resp_data_o)
  );

  resp_credit #(
    .RESP_CREDITS(RESP_CREDITS)
  ) u_resp_credit (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .take_i  (cmd_accept),
    .refund_i(s1_v_r && chk_poison_i),
    .return_i(resp_credit_i),
    .avail_o (cmd_ready_o)
  );

  // Response stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= s1_live;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_live) begin
      resp_vaddr_o              <= s1_vaddr_r;
      resp_tlb_miss_o           <= s1_miss;
      resp_load_page_fault_o    <= lpf;
      resp_store_page_fault_o   <= spf;
      resp_load_access_fault_o  <= laf;
      resp_store_access_fault_o <= saf;
    end
  end

  // Responses delivered whose credit has not come back yet
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owed_r <= '0;
    end else begin
      owed_r <= owed_r + OWED_W'(resp_v_o) - OWED_W'(resp_credit_i);
    end
  end

  // Commands in flight plus unreturned responses stay within the credits
  a_resp_has_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    (int'(owed_r) + int'(s1_v_r) + int'(resp_v_o)) <= RESP_CREDITS);

endmodule

/* resp_credit.sv */
`timescale 1ns/1ps

module resp_credit #(
  parameter int RESP_CREDITS = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic take_i,
  input  logic refund_i,
  input  logic return_i,
  output logic avail_o
);

  // One spare value so an overrun shows up instead of wrapping
  localparam int CNT_W = $clog2(RESP_CREDITS + 2);

  logic [CNT_W-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= CNT_W'(RESP_CREDITS);
    end else begin
      count_r <= count_r + CNT_W'(refund_i) + CNT_W'(return_i) - CNT_W'(take_i);
    end
  end

  assign avail_o = count_r != '0;

  a_no_overrun: assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= CNT_W'(RESP_CREDITS));

  a_no_take_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    take_i |-> count_r != '0);

endmodule

/* tb_mmu.sv */
`timescale 1ns/1ps

module tb_mmu;

  localparam int TLB_ENTRIES  = 4;
  localparam int MEM_DWORDS   = 64;
  localparam int RESP_CREDITS = 2;
  localparam int CYCLE_LIMIT  = 400;

  // Virtual pages used by the translated tests
  localparam logic [26:0] V_A   = 27'h00040;
  localparam logic [26:0] V_U   = 27'h00041;
  localparam logic [26:0] V_K   = 27'h00042;
  localparam logic [26:0] V_NW  = 27'h00043;
  localparam logic [26:0] V_ND  = 27'h00044;
  localparam logic [26:0] V_DOM = 27'h00045;
  localparam logic [26:0] V_C   = 27'h00046;
  localparam logic [26:0] V_NC  = 27'h00047;

  typedef struct packed {
    int                          due;
    logic [mmu_pkg::VADDR_W-1:0] vaddr;
    logic [mmu_pkg::DWORD_W-1:0] data;
    logic                        chk;
    logic [4:0]                  flags;
  } exp_t;

  logic                        clk_i;
  logic                        reset_i;
  logic                        cmd_v_i;
  mmu_pkg::mem_op_e            cmd_op_i;
  logic [mmu_pkg::VADDR_W-1:0] cmd_vaddr_i;
  logic [mmu_pkg::DWORD_W-1:0] cmd_data_i;
  logic                        cmd_ready_o;
  logic                        chk_poison_i;
  logic                        translation_en_i;
  mmu_pkg::priv_e              priv_i;
  logic                        sum_i;
  logic                        uncached_mode_i;
  logic                        fill_v_i;
  logic [mmu_pkg::VTAG_W-1:0]  fill_vtag_i;
  mmu_pkg::pte_leaf_t          fill_entry_i;
  logic                        flush_i;
  logic                        resp_credit_i = 1'b0;
  logic                        resp_v_o;
  logic [mmu_pkg::DWORD_W-1:0] resp_data_o;
  logic [mmu_pkg::VADDR_W-1:0] resp_vaddr_o;
  logic                        resp_tlb_miss_o;
  logic                        resp_load_page_fault_o;
  logic                        resp_store_page_fault_o;
  logic                        resp_load_access_fault_o;
  logic                        resp_store_access_fault_o;

  logic [63:0]        seed = 64'd71;
  logic [63:0]        ref_mem [MEM_DWORDS];
  mmu_pkg::pte_leaf_t ref_tlb [logic [mmu_pkg::VTAG_W-1:0]];
  exp_t               exp_q [$];

  logic        head_v = 1'b0;
  int          head_due = 0;
  logic [38:0] head_vaddr;
  logic [63:0] head_data;
  logic        head_chk;
  logic [4:0]  head_flags;

  int    cycle = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    test_errors = 0;
  string test_name = "reset";
  logic  hold_credits = 1'b0;
  logic  give_credit = 1'b0;
  logic  credit_next;

  mmu_top #(
    .TLB_ENTRIES (TLB_ENTRIES),
    .MEM_DWORDS  (MEM_DWORDS),
    .RESP_CREDITS(RESP_CREDITS)
  ) dut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // Consumer hands back one credit the cycle after each response
  always @(posedge clk_i) begin
    credit_next = (resp_v_o && !hold_credits) || give_credit;
    #10;
    resp_credit_i = credit_next;
  end

  function automatic logic [63:0] next_rand();
    seed = seed * 64'd6364136223846793005 + 64'd1442695040888963407;
    return seed;
  endfunction

  function automatic logic [38:0] page_addr(input logic [26:0] vtag);
    return {vtag, 12'h100};
  endfunction

  function automatic void load_head();
    head_v = exp_q.size() != 0;
    if (head_v) begin
      head_due   = exp_q[0].due;
      head_vaddr = exp_q[0].vaddr;
      head_data  = exp_q[0].data;
      head_chk   = exp_q[0].chk;
      head_flags = exp_q[0].flags;
    end
  endfunction

  // Retire the head once its response edge has passed
  always @(posedge clk_i) begin
    if (head_v && head_due <= cycle) begin
      void'(exp_q.pop_front());
    end
    load_head();
  end

  task automatic report_mismatch(input string field, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("MISMATCH %s %s: expected %h, actual %h", test_name, field, exp_val, act_val);
    errors++;
  endtask

  a_no_extra: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> (head_v && head_due == cycle))
    else begin
      $display("Unexpected response in test %s at cycle %0d", test_name, $sampled(cycle));
      errors++;
    end

  a_no_missing: assert property (@(posedge clk_i) disable iff (reset_i)
    (head_v && head_due == cycle) |-> resp_v_o)
    else begin
      $display("Missing response in test %s at cycle %0d", test_name, $sampled(cycle));
      errors++;
    end

  a_vaddr: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && head_v) |-> resp_vaddr_o == head_vaddr)
    else report_mismatch("vaddr", 64'($sampled(head_vaddr)), 64'($sampled(resp_vaddr_o)));

  a_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && head_v) |-> {resp_tlb_miss_o, resp_load_page_fault_o,
      resp_store_page_fault_o, resp_load_access_fault_o,
      resp_store_access_fault_o} == head_flags)
    else report_mismatch("flags", 64'($sampled(head_flags)),
      64'($sampled({resp_tlb_miss_o, resp_load_page_fault_o, resp_store_page_fault_o,
                    resp_load_access_fault_o, resp_store_access_fault_o})));

  a_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && head_v && head_chk) |-> resp_data_o == head_data)
    else report_mismatch("data", $sampled(head_data), $sampled(resp_data_o));

  // Reference model of translation, faults and scratchpad
  task automatic predict(input mmu_pkg::mem_op_e op, input logic [38:0] vaddr,
                         input logic [63:0] data);
    exp_t               e;
    mmu_pkg::pte_leaf_t ent;
    logic [39:0]        paddr;
    logic               st;
    logic               miss;
    logic               pf;
    logic               af;
    logic [31:0]        word;
    int                 idx;
    e     = '0;
    ent   = '0;
    miss  = 1'b0;
    paddr = {1'b0, vaddr};
    st    = (op == mmu_pkg::op_sd) || (op == mmu_pkg::op_sw);
    if (translation_en_i) begin
      if (ref_tlb.exists(vaddr[38:12])) begin
        ent   = ref_tlb[vaddr[38:12]];
        paddr = {ent.ptag, vaddr[11:0]};
      end else begin
        miss = 1'b1;
      end
    end
    pf = translation_en_i && !miss
         && ((priv_i == mmu_pkg::priv_s && !sum_i && ent.u)
             || (priv_i == mmu_pkg::priv_u && !ent.u)
             || (st && !(ent.w && ent.d)));
    af = !miss && !pf && (paddr[39:37] != 3'b000 || (uncached_mode_i && paddr[31]));
    idx  = int'((paddr >> 3) % MEM_DWORDS);
    word = paddr[2] ? ref_mem[idx][63:32] : ref_mem[idx][31:0];
    if (!miss && !pf && !af) begin
      case (op)
        mmu_pkg::op_sd: ref_mem[idx] = data;
        mmu_pkg::op_sw: begin
          if (paddr[2]) begin
            ref_mem[idx][63:32] = data[31:0];
          end else begin
            ref_mem[idx][31:0] = data[31:0];
          end
        end
        mmu_pkg::op_lw: begin
          e.chk  = 1'b1;
          e.data = {{32{word[31]}}, word};
        end
        default: begin
          e.chk  = 1'b1;
          e.data = ref_mem[idx];
        end
      endcase
    end
    e.due   = cycle + 1;
    e.vaddr = vaddr;
    e.flags = {miss, !st && pf, st && pf, !st && af, st && af};
    exp_q.push_back(e);
  endtask

  task automatic send(input mmu_pkg::mem_op_e op, input logic [38:0] vaddr,
                      input logic [63:0] data, input logic poison);
    cmd_v_i     = 1'b1;
    cmd_op_i    = op;
    cmd_vaddr_i = vaddr;
    cmd_data_i  = data;
    while (!cmd_ready_o) begin
      @(posedge clk_i);
      #10;
      chk_poison_i = 1'b0;
    end
    @(posedge clk_i);
    #10;
    cmd_v_i      = 1'b0;
    chk_poison_i = poison;
    if (!poison) begin
      predict(op, vaddr, data);
    end
  endtask

  task automatic idle(input int n);
    cmd_v_i = 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      #10;
      chk_poison_i = 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(2);
  endtask

  task automatic fill_page(input logic [26:0] vtag, input logic [27:0] ptag,
                           input logic u, input logic w, input logic d);
    fill_v_i     = 1'b1;
    fill_vtag_i  = vtag;
    fill_entry_i = {ptag, u, w, d};
    ref_tlb[vtag] = {ptag, u, w, d};
    @(posedge clk_i);
    #10;
    fill_v_i = 1'b0;
  endtask

  task automatic flush_tlb();
    flush_i = 1'b1;
    ref_tlb.delete();
    @(posedge clk_i);
    #10;
    flush_i = 1'b0;
  endtask

  task automatic return_credit();
    give_credit = 1'b1;
    @(posedge clk_i);
    #10;
    give_credit = 1'b0;
    @(posedge clk_i);
    #10;
  endtask

  task automatic expect_ready(input logic want);
    assert (cmd_ready_o == want)
      else report_mismatch("cmd_ready", 64'(want), 64'(cmd_ready_o));
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s done with %0d errors", test_name, errors - test_errors);
  endtask

  initial begin
    wait (cycle >= CYCLE_LIMIT);
    $display("Timeout: run stopped after %0d cycles in test %s", CYCLE_LIMIT, test_name);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_op_i         = mmu_pkg::op_ld;
    cmd_vaddr_i      = '0;
    cmd_data_i       = '0;
    chk_poison_i     = 1'b0;
    translation_en_i = 1'b0;
    priv_i           = mmu_pkg::priv_s;
    sum_i            = 1'b0;
    uncached_mode_i  = 1'b0;
    fill_v_i         = 1'b0;
    fill_vtag_i      = '0;
    fill_entry_i     = '0;
    flush_i          = 1'b0;
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;

    // Bare mode stores and loads, back to back
    start_test("bare");
    send(mmu_pkg::op_sd, 39'h100, next_rand(), 1'b0);
    send(mmu_pkg::op_ld, 39'h100, '0, 1'b0);
    send(mmu_pkg::op_sd, 39'h108, next_rand() | 64'h8000_0000_8000_0000, 1'b0);
    send(mmu_pkg::op_lw, 39'h108, '0, 1'b0);
    send(mmu_pkg::op_lw, 39'h10c, '0, 1'b0);
    send(mmu_pkg::op_sw, 39'h10c, next_rand(), 1'b0);
    send(mmu_pkg::op_ld, 39'h108, '0, 1'b0);
    drain();
    end_test();

    start_test("tlb");
    flush_tlb();
    translation_en_i = 1'b1;
    send(mmu_pkg::op_ld, page_addr(V_A), '0, 1'b0);
    send(mmu_pkg::op_sd, page_addr(V_A), next_rand(), 1'b0);
    drain();
    fill_page(V_A, 28'h0000003, 1'b0, 1'b1, 1'b1);
    send(mmu_pkg::op_ld, page_addr(V_A), '0, 1'b0);
    send(mmu_pkg::op_sd, page_addr(V_A), next_rand(), 1'b0);
    send(mmu_pkg::op_ld, page_addr(V_A), '0, 1'b0);
    drain();
    flush_tlb();
    send(mmu_pkg::op_ld, page_addr(V_A), '0, 1'b0);
    drain();
    end_test();

    start_test("page_fault");
    flush_tlb();
    fill_page(V_U, 28'h0000004, 1'b1, 1'b1, 1'b1);
    fill_page(V_K, 28'h0000005, 1'b0, 1'b1, 1'b1);
    fill_page(V_NW, 28'h0000006, 1'b0, 1'b0, 1'b1);
    fill_page(V_ND, 28'h0000007, 1'b0, 1'b1, 1'b0);
    send(mmu_pkg::op_ld, page_addr(V_U), '0, 1'b0);
    drain();
    sum_i = 1'b1;
    send(mmu_pkg::op_ld, page_addr(V_U), '0, 1'b0);
    drain();
    sum_i  = 1'b0;
    priv_i = mmu_pkg::priv_u;
    send(mmu_pkg::op_ld, page_addr(V_K), '0, 1'b0);
    drain();
    priv_i = mmu_pkg::priv_s;
    send(mmu_pkg::op_sd, page_addr(V_NW), next_rand(), 1'b0);
    send(mmu_pkg::op_sd, page_addr(V_ND), next_rand(), 1'b0);
    send(mmu_pkg::op_ld, page_addr(V_K), '0, 1'b0);
    drain();
    end_test();

    // Domain 1 page, then cached and uncached pages
    start_test("access_fault");
    flush_tlb();
    fill_page(V_DOM, 28'h2000008, 1'b0, 1'b1, 1'b1);
    fill_page(V_C, 28'h0080009, 1'b0, 1'b1, 1'b1);
    fill_page(V_NC, 28'h000000a, 1'b0, 1'b1, 1'b1);
    send(mmu_pkg::op_ld, page_addr(V_DOM), '0, 1'b0);
    send(mmu_pkg::op_sd, page_addr(V_DOM), next_rand(), 1'b0);
    send(mmu_pkg::op_ld, page_addr(V_C), '0, 1'b0);
    drain();
    uncached_mode_i = 1'b1;
    send(mmu_pkg::op_ld, page_addr(V_C), '0, 1'b0);
    send(mmu_pkg::op_ld, page_addr(V_NC), '0, 1'b0);
    send(mmu_pkg::op_sd, page_addr(V_C), next_rand(), 1'b0);
    drain();
    uncached_mode_i  = 1'b0;
    translation_en_i = 1'b0;
    end_test();

    // Full credits so the follower is accepted right behind the poisoned one
    start_test("poison");
    send(mmu_pkg::op_sd, 39'h100, next_rand(), 1'b0);
    drain();
    send(mmu_pkg::op_sd, 39'h100, next_rand(), 1'b1);
    send(mmu_pkg::op_ld, 39'h100, '0, 1'b0);
    drain();
    send(mmu_pkg::op_ld, 39'h108, '0, 1'b1);
    send(mmu_pkg::op_ld, 39'h108, '0, 1'b0);
    drain();
    end_test();

    start_test("credits");
    hold_credits = 1'b1;
    send(mmu_pkg::op_ld, 39'h100, '0, 1'b0);
    send(mmu_pkg::op_ld, 39'h108, '0, 1'b0);
    expect_ready(1'b0);
    repeat (4) begin
      idle(1);
      expect_ready(1'b0);
    end
    return_credit();
    expect_ready(1'b1);
    return_credit();
    expect_ready(1'b1);
    // Poisoned second command refunds on its own
    send(mmu_pkg::op_ld, 39'h100, '0, 1'b0);
    send(mmu_pkg::op_ld, 39'h108, '0, 1'b1);
    expect_ready(1'b0);
    idle(1);
    expect_ready(1'b1);
    idle(3);
    expect_ready(1'b1);
    return_credit();
    hold_credits = 1'b0;
    drain();
    end_test();

    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
